/* verilog/ufiPkg.sv */
// --------------------------------------------------------------------------
// UFI RAM interface definitions
// Bus widths, command word fields, RAM geometry and the port structs
// shared by the arbiter, the block RAM and the top level
// --------------------------------------------------------------------------
package ufiPkg;

	// Bus widths
	localparam int UFI_DQ_BITS = 16;
	localparam int UFI_ADRS_BITS = 32;

	// Command word fields, bit 29 reserved
	localparam int UFI_ENABLE_BIT = 31;
	localparam int UFI_READ_BIT = 30;
	localparam int UFI_BLOCK_LSB = 25;
	localparam int UFI_BLOCK_BITS = 4;

	// RAM geometry, upper address bits alias
	localparam int RAM_WORD_BITS = 6;
	localparam int RAM_DEPTH = 2 ** (UFI_BLOCK_BITS + RAM_WORD_BITS);
	localparam int RAM_READ_LATENCY = 3;

	// Depth of every arbiter queue
	localparam int FIFO_DEPTH = 16;

	typedef logic [UFI_DQ_BITS-1:0] ufiDqT;
	typedef logic [UFI_ADRS_BITS-1:0] ufiAdrsT;
	// Block ID on top, low word bits below
	typedef logic [UFI_BLOCK_BITS+RAM_WORD_BITS-1:0] ramIndexT;

	// Command, bus side and RAM side
	typedef struct packed {
		ufiAdrsT adrs;
		ufiDqT dq;
	} ufiCmdT;

	// Read response with echoed command word
	typedef struct packed {
		ufiAdrsT adrs;
		ufiDqT dq;
	} ufiRspT;

	// RAM read return
	typedef struct packed {
		logic valid;
		ufiDqT dq;
	} ramRdT;

endpackage

/* verilog/syncFifo.sv */
// --------------------------------------------------------------------------
// Synchronous FIFO
// Circular buffer with first-word-fall-through output and full/empty flags
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module syncFifo #(
	parameter int WIDTH = 8,
	parameter int DEPTH = 16
)(
	input  logic iCLK,
	input  logic rstN,
	input  logic [WIDTH-1:0] wrData,
	input  logic wrEn,
	output logic [WIDTH-1:0] rdData,
	input  logic rdEn,
	output logic full,
	output logic empty
);
	localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [WIDTH-1:0] mem [DEPTH];
	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	// One extra bit so count can reach DEPTH
	logic [PTR_BITS:0] count;
	logic doWrite;
	logic doRead;

	assign doWrite = wrEn && !full;
	assign doRead = rdEn && !empty;
	assign full = (count == (PTR_BITS + 1)'(DEPTH));
	assign empty = (count == '0);
	// Head word always on the output
	assign rdData = mem[rdPtr];

	// Storage
	always_ff @(posedge iCLK)
	begin
		if (doWrite)
			mem[wrPtr] <= wrData;
	end

	// Pointers and occupancy
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWrite)
				wrPtr <= (wrPtr == PTR_BITS'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doRead)
				rdPtr <= (rdPtr == PTR_BITS'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			if (doWrite && !doRead)
				count <= count + 1'b1;
			else if (doRead && !doWrite)
				count <= count - 1'b1;
		end
	end

	// Caller must respect the flags
	assert property (@(posedge iCLK) disable iff (!rstN) wrEn |-> !full)
		else $error("syncFifo: write while full");
	assert property (@(posedge iCLK) disable iff (!rstN) rdEn |-> !empty)
		else $error("syncFifo: read while empty");

endmodule

/* verilog/ramReadWriteArbiter.sv */
// --------------------------------------------------------------------------
// RAM read/write arbiter
// Queues enabled bus commands toward the RAM port, keeps the command word
// of every pending read and pairs it with the returning RAM data
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module ramReadWriteArbiter
	import ufiPkg::*;
(
	input  logic iCLK,
	input  logic rstN,
	// Bus command port
	input  ufiCmdT cmd,
	output logic rdy,
	// Bus response port without ready
	output ufiRspT rsp,
	// RAM command port
	output ufiCmdT ramCmd,
	input  logic ramRdy,
	// RAM read return
	input  ramRdT ramRd
);

	// ----------------------------------------------------------------------
	// Command side
	// ----------------------------------------------------------------------
	logic cmdAccept;
	logic cmdIsRead;
	logic cmdQFull;
	logic cmdQEmpty;
	logic cmdQPop;
	ufiCmdT cmdHead;
	logic pendQFull;
	logic pendQEmpty;
	ufiAdrsT pendHead;
	logic rspPop;

	assign cmdIsRead = cmd.adrs[UFI_READ_BIT];
	// Stall when either queue runs out of room
	assign rdy = !cmdQFull && !pendQFull;
	// Enable bit doubles as valid
	assign cmdAccept = cmd.adrs[UFI_ENABLE_BIT] && rdy;

	syncFifo #(
		.WIDTH($bits(ufiCmdT)),
		.DEPTH(FIFO_DEPTH)
	) commandQueue (
		.iCLK(iCLK),
		.rstN(rstN),
		.wrData(cmd),
		.wrEn(cmdAccept),
		.rdData(cmdHead),
		.rdEn(cmdQPop),
		.full(cmdQFull),
		.empty(cmdQEmpty)
	);

	// Head goes out whenever the RAM takes it
	assign cmdQPop = !cmdQEmpty && ramRdy;
	assign ramCmd = cmdQEmpty ? '0 : cmdHead;

	// Command words of reads in flight
	syncFifo #(
		.WIDTH($bits(ufiAdrsT)),
		.DEPTH(FIFO_DEPTH)
	) pendingReadQueue (
		.iCLK(iCLK),
		.rstN(rstN),
		.wrData(cmd.adrs),
		.wrEn(cmdAccept && cmdIsRead),
		.rdData(pendHead),
		.rdEn(rspPop),
		.full(pendQFull),
		.empty(pendQEmpty)
	);

	// ----------------------------------------------------------------------
	// Response side
	// ----------------------------------------------------------------------
	logic rdQFull;
	logic rdQEmpty;
	ufiDqT rdHead;
	ufiAdrsT rspAdrsQ;
	ufiDqT rspDqQ;

	syncFifo #(
		.WIDTH($bits(ufiDqT)),
		.DEPTH(FIFO_DEPTH)
	) readDataQueue (
		.iCLK(iCLK),
		.rstN(rstN),
		.wrData(ramRd.dq),
		.wrEn(ramRd.valid),
		.rdData(rdHead),
		.rdEn(rspPop),
		.full(rdQFull),
		.empty(rdQEmpty)
	);

	// Data and its command word leave together
	assign rspPop = !rdQEmpty;

	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			rspAdrsQ <= '0;
		else
			rspAdrsQ <= rspPop ? pendHead : '0;
	end

	always_ff @(posedge iCLK)
	begin
		rspDqQ <= rdHead;
	end

	assign rsp = '{adrs: rspAdrsQ, dq: rspDqQ};

	// Returned data always has a pending command word, so the
	// data queue stays bounded by the pending queue
	assert property (@(posedge iCLK) disable iff (!rstN)
		ramRd.valid |-> (!pendQEmpty && !rdQFull))
		else $error("arbiter: read data without pending read");

endmodule

/* verilog/ramBlockMemory.sv */
// --------------------------------------------------------------------------
// Blocked on-chip RAM
// 16 blocks of 64 words with a fixed read latency and a one-cycle
// busy whenever the transfer direction changes
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module ramBlockMemory
	import ufiPkg::*;
(
	input  logic iCLK,
	input  logic rstN,
	input  ufiCmdT ramCmd,
	output logic ramRdy,
	output ramRdT ramRd
);
	logic xfer;
	logic xferRead;
	ramIndexT index;
	ufiDqT mem [RAM_DEPTH];
	logic [RAM_READ_LATENCY-1:0] validPipe;
	ufiDqT dataPipe [RAM_READ_LATENCY];
	logic lastRead;
	logic busy;

	assign xfer = ramCmd.adrs[UFI_ENABLE_BIT] && ramRdy;
	assign xferRead = ramCmd.adrs[UFI_READ_BIT];
	// Block ID then low word bits, rest of the address ignored
	assign index = {ramCmd.adrs[UFI_BLOCK_LSB +: UFI_BLOCK_BITS],
		ramCmd.adrs[RAM_WORD_BITS-1:0]};
	assign ramRdy = !busy;

	// ----------------------------------------------------------------------
	// Word array
	// ----------------------------------------------------------------------
	// Write commits at the transfer edge
	always_ff @(posedge iCLK)
	begin
		if (xfer && !xferRead)
			mem[index] <= ramCmd.dq;
	end

	// ----------------------------------------------------------------------
	// Read latency pipeline
	// ----------------------------------------------------------------------
	// Data stages, several reads in flight
	always_ff @(posedge iCLK)
	begin
		dataPipe[0] <= mem[index];
		for (int i = 1; i < RAM_READ_LATENCY; i++)
			dataPipe[i] <= dataPipe[i-1];
	end

	// Valid stages
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
			validPipe <= '0;
		else
		begin
			validPipe[0] <= xfer && xferRead;
			for (int i = 1; i < RAM_READ_LATENCY; i++)
				validPipe[i] <= validPipe[i-1];
		end
	end

	assign ramRd = '{valid: validPipe[RAM_READ_LATENCY-1],
		dq: dataPipe[RAM_READ_LATENCY-1]};

	// ----------------------------------------------------------------------
	// Direction turnaround
	// ----------------------------------------------------------------------
	// Starts out as write, so a first read pays the turnaround too
	always_ff @(posedge iCLK or negedge rstN)
	begin
		if (!rstN)
		begin
			lastRead <= 1'b0;
			busy <= 1'b0;
		end
		else
		begin
			busy <= xfer && (xferRead != lastRead);
			if (xfer)
				lastRead <= xferRead;
		end
	end

	// Arbiter must hold a stalled command
	assert property (@(posedge iCLK) disable iff (!rstN)
		(ramCmd.adrs[UFI_ENABLE_BIT] && !ramRdy) |=> $stable(ramCmd))
		else $error("ramBlockMemory: command changed while busy");

endmodule

/* verilog/ramIfTop.sv */
// --------------------------------------------------------------------------
// RAM interface top level
// Arbiter in front of the blocked RAM, bus ports on the outside
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module ramIfTop
	import ufiPkg::*;
(
	input  logic iCLK,
	input  logic rstN,
	input  ufiCmdT cmd,
	output logic rdy,
	output ufiRspT rsp
);
	// Arbiter to RAM
	ufiCmdT ramCmd;
	logic ramRdy;
	// RAM back to arbiter
	ramRdT ramRd;

	ramReadWriteArbiter ramReadWriteArbiter_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.cmd(cmd),
		.rdy(rdy),
		.rsp(rsp),
		.ramCmd(ramCmd),
		.ramRdy(ramRdy),
		.ramRd(ramRd)
	);

	ramBlockMemory ramBlockMemory_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.ramCmd(ramCmd),
		.ramRdy(ramRdy),
		.ramRd(ramRd)
	);

endmodule

/* sim/tbClockGen.sv */
// --------------------------------------------------------------------------
// Testbench clock and reset
// Free-running clock, reset held low for a few cycles after start
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module tbClockGen #(
	parameter int PERIOD = 4,
	parameter int RESET_CYCLES = 4
)(
	output logic iCLK,
	output logic rstN
);

	initial
	begin
		iCLK = 1'b0;
		forever
			#(PERIOD / 2) iCLK = ~iCLK;
	end

	// Release away from the active edge
	initial
	begin
		rstN = 1'b0;
		repeat (RESET_CYCLES) @(posedge iCLK);
		@(negedge iCLK);
		rstN = 1'b1;
	end

endmodule

/* sim/ramIfTb.sv */
// --------------------------------------------------------------------------
// RAM interface testbench
// Random commands against a reference memory, response order and data
// checks, back-pressure and disabled command handling
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module ramIfTb
	import ufiPkg::*;
();
	localparam int CLK_PERIOD = 4;
	localparam int WRITE_READ_COUNT = 32;
	localparam int MIX_COUNT = 300;
	localparam int DISABLED_COUNT = 40;
	localparam int BURST_COUNT = 64;
	localparam int CYCLES_PER_COMMAND = 40;
	localparam int COMMAND_TOTAL = 2 * WRITE_READ_COUNT + MIX_COUNT + 2 * DISABLED_COUNT
		+ BURST_COUNT;
	localparam int DRAIN_LIMIT = 400;

	logic iCLK;
	logic rstN;
	ufiCmdT cmd;
	logic rdy;
	ufiRspT rsp;

	integer seed;
	int errorCount;
	int testCount;
	int failedTests;
	int checkCount;
	int readsIssued;
	int responseCount;
	int stallCycles;

	// Reference memory keyed like the RAM
	ufiDqT model [ramIndexT];
	ramIndexT writtenQ[$];
	// Expected responses in issue order
	ufiAdrsT expAdrsQ[$];
	ufiDqT expDqQ[$];
	ufiAdrsT monAdrs;
	ufiDqT monDq;

	tbClockGen #(
		.PERIOD(CLK_PERIOD),
		.RESET_CYCLES(4)
	) tbClockGen_i (
		.iCLK(iCLK),
		.rstN(rstN)
	);

	ramIfTop ramIfTop_i (
		.iCLK(iCLK),
		.rstN(rstN),
		.cmd(cmd),
		.rdy(rdy),
		.rsp(rsp)
	);

	// --------------------------------------------------------------------------
	// Helpers
	// --------------------------------------------------------------------------
	// Block ID above the low 6 address bits
	function automatic ramIndexT indexOf(input ufiAdrsT word);
		return {word[UFI_BLOCK_LSB +: UFI_BLOCK_BITS], word[RAM_WORD_BITS-1:0]};
	endfunction

	// Ignored bits stay random so aliases get exercised
	function automatic ufiAdrsT makeWord(input logic isRead, input ramIndexT idx);
		ufiAdrsT word;
		word = $random(seed);
		word[UFI_ENABLE_BIT] = 1'b1;
		word[UFI_READ_BIT] = isRead;
		word[UFI_BLOCK_LSB +: UFI_BLOCK_BITS] = idx[RAM_WORD_BITS +: UFI_BLOCK_BITS];
		word[RAM_WORD_BITS-1:0] = idx[RAM_WORD_BITS-1:0];
		return word;
	endfunction

	function automatic ramIndexT pickWritten();
		return writtenQ[$unsigned($random(seed)) % writtenQ.size()];
	endfunction

	// Driven on the falling edge and held until accepted
	task automatic issueCommand(input ufiAdrsT word, input ufiDqT data);
		ramIndexT idx;
		idx = indexOf(word);
		@(negedge iCLK);
		cmd = '{adrs: word, dq: data};
		while (!rdy)
		begin
			stallCycles++;
			@(negedge iCLK);
		end
		@(posedge iCLK);
		// Accepted here so the model follows queue order
		if (word[UFI_READ_BIT])
		begin
			expAdrsQ.push_back(word);
			expDqQ.push_back(model[idx]);
			readsIssued++;
		end
		else
		begin
			if (!model.exists(idx))
				writtenQ.push_back(idx);
			model[idx] = data;
		end
	endtask

	task automatic writeIndex(input ramIndexT idx, input ufiDqT data);
		ufiAdrsT word;
		word = makeWord(1'b0, idx);
		issueCommand(word, data);
	endtask

	task automatic readIndex(input ramIndexT idx);
		ufiAdrsT word;
		ufiDqT junk;
		word = makeWord(1'b1, idx);
		junk = ufiDqT'($random(seed));
		issueCommand(word, junk);
	endtask

	task automatic idleBus();
		@(negedge iCLK);
		cmd = '0;
	endtask

	// Bounded wait for every pending read
	task automatic waitForDrain();
		int cycles;
		idleBus();
		cycles = 0;
		while (expAdrsQ.size() > 0 && cycles < DRAIN_LIMIT)
		begin
			@(posedge iCLK);
			cycles++;
		end
		checkCount++;
		assert (expAdrsQ.size() == 0)
		else
		begin
			$display("ERROR: %0d read responses never arrived", expAdrsQ.size());
			errorCount++;
		end
	endtask

	task automatic reportTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore)
			$display("Test %0d %s: PASS", testCount, name);
		else
		begin
			failedTests++;
			$display("Test %0d %s: FAIL with %0d errors", testCount, name,
				errorCount - errorsBefore);
		end
	endtask

	// --------------------------------------------------------------------------
	// Response monitor
	// --------------------------------------------------------------------------
	// Registered outputs are stable at the falling edge
	always @(negedge iCLK)
	begin
		if (rstN && rsp.adrs[UFI_ENABLE_BIT])
		begin
			responseCount++;
			checkCount++;
			assert (expAdrsQ.size() > 0)
			else
			begin
				$display("ERROR: response with no read pending, command word %h", rsp.adrs);
				errorCount++;
			end
			if (expAdrsQ.size() > 0)
			begin
				monAdrs = expAdrsQ.pop_front();
				monDq = expDqQ.pop_front();
				checkCount += 2;
				assert (rsp.adrs === monAdrs)
				else
				begin
					$display("FAIL rsp.adrs expected %h got %h", monAdrs, rsp.adrs);
					errorCount++;
				end
				assert (rsp.dq === monDq)
				else
				begin
					$display("FAIL rsp.dq expected %h got %h", monDq, rsp.dq);
					errorCount++;
				end
			end
		end
	end

	// Watchdog sized from the command count
	initial
	begin
		@(posedge rstN);
		repeat (COMMAND_TOTAL * CYCLES_PER_COMMAND) @(posedge iCLK);
		$display("ERROR: run did not finish within %0d cycles",
			COMMAND_TOTAL * CYCLES_PER_COMMAND);
		$display("Test failures found");
		$finish;
	end

	// --------------------------------------------------------------------------
	// Test sequence
	// --------------------------------------------------------------------------
	initial
	begin : mainSequence
		int errorsBefore;
		int countBefore;
		ufiDqT data;
		ramIndexT idx;
		ramIndexT touchedQ[$];
		ufiAdrsT word;
		logic doRead;
		seed = 56151;
		cmd = '0;
		errorCount = 0;
		testCount = 0;
		failedTests = 0;
		checkCount = 0;
		readsIssued = 0;
		responseCount = 0;
		stallCycles = 0;
		@(posedge rstN);

		// Reset state
		errorsBefore = errorCount;
		repeat (4)
		begin
			@(negedge iCLK);
			checkCount += 2;
			assert (rdy === 1'b1)
			else
			begin
				$display("FAIL rdy expected %h got %h", 1'b1, rdy);
				errorCount++;
			end
			assert (rsp.adrs[UFI_ENABLE_BIT] === 1'b0)
			else
			begin
				$display("FAIL rsp.adrs[31] expected %h got %h", 1'b0,
					rsp.adrs[UFI_ENABLE_BIT]);
				errorCount++;
			end
		end
		reportTest("reset state", errorsBefore);

		// Write then read back
		errorsBefore = errorCount;
		for (int i = 0; i < WRITE_READ_COUNT; i++)
		begin
			idx = ramIndexT'($random(seed));
			// Upper byte keeps values distinct
			data = {8'(i), 8'($random(seed))};
			writeIndex(idx, data);
			touchedQ.push_back(idx);
		end
		foreach (touchedQ[i])
			readIndex(touchedQ[i]);
		waitForDrain();
		reportTest("write then read back", errorsBefore);

		// Random mix with reads only from written words
		errorsBefore = errorCount;
		for (int i = 0; i < MIX_COUNT; i++)
		begin
			doRead = 1'($random(seed));
			if (doRead)
				readIndex(pickWritten());
			else
			begin
				idx = ramIndexT'($random(seed));
				data = ufiDqT'($random(seed));
				writeIndex(idx, data);
			end
		end
		waitForDrain();
		reportTest("random mix", errorsBefore);

		// Disabled commands aimed at written words
		errorsBefore = errorCount;
		countBefore = responseCount;
		touchedQ = {};
		for (int i = 0; i < DISABLED_COUNT; i++)
		begin
			idx = pickWritten();
			word = makeWord(1'($random(seed)), idx);
			word[UFI_ENABLE_BIT] = 1'b0;
			data = ufiDqT'($random(seed));
			@(negedge iCLK);
			cmd = '{adrs: word, dq: data};
			touchedQ.push_back(idx);
		end
		idleBus();
		// Quiet window longer than any read path
		repeat (4 * FIFO_DEPTH) @(posedge iCLK);
		checkCount++;
		assert (responseCount == countBefore)
		else
		begin
			$display("FAIL responseCount expected %h got %h", countBefore, responseCount);
			errorCount++;
		end
		foreach (touchedQ[i])
			readIndex(touchedQ[i]);
		waitForDrain();
		reportTest("disabled commands", errorsBefore);

		// Alternating burst where every transfer turns the bus around
		errorsBefore = errorCount;
		stallCycles = 0;
		for (int i = 0; i < BURST_COUNT; i++)
		begin
			if (i % 2 == 0)
			begin
				idx = ramIndexT'($random(seed));
				data = ufiDqT'($random(seed));
				writeIndex(idx, data);
			end
			else
				readIndex(pickWritten());
		end
		waitForDrain();
		checkCount += 2;
		assert (stallCycles > 0)
		else
		begin
			$display("ERROR: rdy never fell during the alternating burst");
			errorCount++;
		end
		assert (responseCount == readsIssued)
		else
		begin
			$display("FAIL responseCount expected %h got %h", readsIssued, responseCount);
			errorCount++;
		end
		reportTest("back-pressure", errorsBefore);

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			testCount, failedTests, checkCount, errorCount);
		if (errorCount == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

/* flist.f */
verilog/ufiPkg.sv
verilog/syncFifo.sv
verilog/ramReadWriteArbiter.sv
verilog/ramBlockMemory.sv
verilog/ramIfTop.sv
sim/tbClockGen.sv
sim/ramIfTb.sv
